// ==== tb.f ====
rtl/demo_pkg.sv
rtl/demo_bus.sv
rtl/demo_ram.sv
rtl/demo_gpio.sv
rtl/demo_timer.sv
rtl/demo_system.sv
verification/tb_clk_gen.sv
verification/tb_demo_system.sv

// ==== run.sh ====
#!/bin/sh
# Build and run with Verilator, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_demo_system -f tb.f -o tb_sim \
  > build.log 2>&1 && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { echo "Build or simulation failed"; exit 1; }
grep -q "Done: errors found" sim.log && { echo "Simulation failed"; exit 1; }
echo "Simulation passed"

// ==== verification/tb_demo_system.sv ====
////////////////////////////////////////////////////////////
// Demo system testbench
////////////////////////////////////////////////////////////
module tb_demo_system;
  timeunit 1ns;
  timeprecision 1ps;
  import demo_pkg::*;

  typedef struct packed {
    logic [BusDataWidth-1:0] data;
    logic                    err;
    logic                    chk;
  } resp_t;

  logic                    clk_sys;
  logic                    rst_sys_n;
  logic                    host_req;
  logic                    host_we;
  logic [BusBeWidth-1:0]   host_be;
  logic [BusAddrWidth-1:0] host_addr;
  logic [BusDataWidth-1:0] host_wdata;
  logic                    host_rvalid;
  logic [BusDataWidth-1:0] host_rdata;
  logic                    host_err;
  logic [GpiWidth-1:0]     gp_in;
  logic [GpoWidth-1:0]     gp_out;
  logic                    timer_irq;

  resp_t                   exp_q[$];
  logic [BusDataWidth-1:0] ram_model [logic [13:0]];
  logic [BusAddrWidth-1:0] ram_addrs [8];
  logic [GpoWidth-1:0]     gpo_model;
  logic [31:0]             rng_state;
  logic [BusDataWidth-1:0] last_rdata;
  logic                    req_seen;
  int                      errors = 0;
  int                      checks = 0;
  int                      issued = 0;
  int                      resp_count = 0;

  tb_clk_gen tb_clk_gen_inst (
    .clk_sys_o (clk_sys),
    .rst_sys_no(rst_sys_n)
  );

  demo_system demo_system_inst (
    .clk_sys_i    (clk_sys),
    .rst_sys_ni   (rst_sys_n),
    .host_req_i   (host_req),
    .host_we_i    (host_we),
    .host_be_i    (host_be),
    .host_addr_i  (host_addr),
    .host_wdata_i (host_wdata),
    .host_rvalid_o(host_rvalid),
    .host_rdata_o (host_rdata),
    .host_err_o   (host_err),
    .gp_i         (gp_in),
    .gp_o         (gp_out),
    .timer_irq_o  (timer_irq)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic in_window(input logic [31:0] addr, input logic [31:0] base,
                                     input logic [31:0] size);
    return (addr & ~(size - 1)) == base;
  endfunction

  function automatic logic [31:0] byte_merge(input logic [31:0] old_word,
                                             input logic [31:0] wdata, input logic [3:0] be);
    logic [31:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_word & ~mask) | (wdata & mask);
  endfunction

  // Expected read data from the testbench model
  function automatic logic [31:0] expected_read(input logic [31:0] addr);
    if (in_window(addr, RamStart, RamSize)) begin
      return ram_model[addr[15:2]];
    end
    if (in_window(addr, GpioStart, GpioSize)) begin
      if (addr[11:0] == 12'h000) return BusDataWidth'(gpo_model);
      if (addr[11:0] == 12'h004) return BusDataWidth'(gp_in);
    end
    return '0;
  endfunction

  function automatic void update_model(input logic [31:0] addr, input logic [31:0] wdata,
                                       input logic [3:0] be);
    logic [31:0] merged;
    if (in_window(addr, RamStart, RamSize)) begin
      merged = ram_model.exists(addr[15:2]) ? ram_model[addr[15:2]] : '0;
      ram_model[addr[15:2]] = byte_merge(merged, wdata, be);
    end else if (in_window(addr, GpioStart, GpioSize) && addr[11:0] == 12'h000) begin
      merged = byte_merge(BusDataWidth'(gpo_model), wdata, be);
      gpo_model = merged[GpoWidth-1:0];
    end
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, expected);
    end
  endtask

  task automatic bus_access(input logic we, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [3:0] be);
    resp_t entry;
    logic  unmapped;
    unmapped = !in_window(addr, RamStart, RamSize) && !in_window(addr, GpioStart, GpioSize)
               && !in_window(addr, TimerStart, TimerSize);
    @(negedge clk_sys);
    host_req   = 1'b1;
    host_we    = we;
    host_be    = be;
    host_addr  = addr;
    host_wdata = wdata;
    entry.err  = unmapped;
    entry.data = we ? '0 : expected_read(addr);
    // Timer reads and write responses carry no checkable data
    entry.chk  = unmapped || (!we && !in_window(addr, TimerStart, TimerSize));
    exp_q.push_back(entry);
    if (we) begin
      update_model(addr, wdata, be);
    end
    issued++;
  endtask

  task automatic bus_idle(input int n);
    repeat (n) begin
      @(negedge clk_sys);
      host_req = 1'b0;
    end
  endtask

  task automatic wait_responses();
    int cycles;
    cycles = 0;
    while (resp_count != issued && cycles < 20) begin
      @(negedge clk_sys);
      cycles++;
    end
    if (resp_count != issued) begin
      errors++;
      $display("Timed out waiting for bus responses: %0d of %0d", resp_count, issued);
    end
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (rst_sys_n !== 1'b1 && cycles < 20) begin
      @(negedge clk_sys);
      cycles++;
    end
    if (rst_sys_n !== 1'b1) begin
      errors++;
      $display("Reset was never released");
    end
  endtask

  // A request seen at a rising edge must be answered before the next one
  initial begin : compare_responses
    resp_t entry;
    forever begin
      @(posedge clk_sys);
      req_seen = host_req;
      @(negedge clk_sys);
      if (host_rvalid !== req_seen) begin
        errors++;
        $display("Response timing wrong: rvalid %b one cycle after request %b",
                 host_rvalid, req_seen);
      end
      if (host_rvalid === 1'b1) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Response arrived with no request outstanding");
        end else begin
          entry = exp_q.pop_front();
          check_value("host_err_o", 32'(host_err), 32'(entry.err));
          if (entry.chk) begin
            check_value("host_rdata_o", host_rdata, entry.data);
          end
          last_rdata = host_rdata;
          resp_count++;
        end
      end
    end
  end

  initial begin : stimulus
    int          cycles;
    logic [31:0] r;
    logic [31:0] t0;
    logic [31:0] t1;
    rng_state  = 32'hf707ef32;
    gpo_model  = '0;
    host_req   = 1'b0;
    host_we    = 1'b0;
    host_be    = '0;
    host_addr  = '0;
    host_wdata = '0;
    gp_in      = '0;
    wait_reset_release();

    // RAM fill, partial update, read back
    for (int i = 0; i < 8; i++) begin
      ram_addrs[i] = RamStart | (next_rand() & 32'h0000_fffc);
      bus_access(1'b1, ram_addrs[i], next_rand(), 4'hf);
    end
    for (int i = 0; i < 8; i++) begin
      bus_access(1'b1, ram_addrs[i], next_rand(), 4'(next_rand()));
    end
    for (int i = 0; i < 8; i++) begin
      bus_access(1'b0, ram_addrs[i], 32'h0, 4'hf);
    end
    bus_idle(1);
    wait_responses();

    for (int i = 0; i < 4; i++) begin
      bus_access(1'b1, GpioStart | 32'(GpioOut), next_rand(), 4'(next_rand()));
      bus_idle(1);
      wait_responses();
      check_value("gp_o", 32'(gp_out), 32'(gpo_model));
      bus_access(1'b0, GpioStart | 32'(GpioOut), 32'h0, 4'hf);
    end
    bus_idle(1);
    wait_responses();

    // Input held long enough to pass the synchroniser
    @(negedge clk_sys);
    gp_in = GpiWidth'(next_rand());
    bus_idle(3);
    bus_access(1'b0, GpioStart | 32'(GpioIn), 32'h0, 4'hf);

    // Unmapped holes and an alias of a RAM word
    bus_access(1'b1, 32'h0000_0000, next_rand(), 4'hf);
    bus_access(1'b0, 32'h8000_1000, 32'h0, 4'hf);
    bus_access(1'b1, 32'h0011_0000 | (ram_addrs[0] & 32'h0000_fffc), next_rand(), 4'hf);
    for (int i = 0; i < 3; i++) begin
      r = next_rand();
      bus_access(r[0], 32'h4000_0000 | (next_rand() & 32'h0fff_fffc), next_rand(), 4'hf);
    end
    bus_access(1'b0, ram_addrs[0], 32'h0, 4'hf);
    bus_idle(1);
    wait_responses();

    bus_access(1'b0, TimerStart | 32'(TimeLo), 32'h0, 4'hf);
    bus_idle(1);
    wait_responses();
    t0 = last_rdata;
    bus_idle(6);
    bus_access(1'b0, TimerStart | 32'(TimeLo), 32'h0, 4'hf);
    bus_idle(1);
    wait_responses();
    t1 = last_rdata;
    checks++;
    if (t1 <= t0) begin
      errors++;
      $display("Timer low word did not advance: first read %h, second read %h", t0, t1);
    end

    bus_access(1'b1, TimerStart | 32'(CmpHi), 32'hffff_ffff, 4'hf);
    bus_access(1'b1, TimerStart | 32'(CmpLo), 32'hffff_ffff, 4'hf);
    bus_idle(3);
    wait_responses();
    repeat (10) begin
      @(negedge clk_sys);
      check_value("timer_irq_o", 32'(timer_irq), 32'h0);
    end
    bus_access(1'b1, TimerStart | 32'(CmpLo), 32'h0, 4'hf);
    bus_access(1'b1, TimerStart | 32'(CmpHi), 32'h0, 4'hf);
    bus_idle(1);
    wait_responses();
    cycles = 0;
    while (timer_irq !== 1'b1 && cycles < 10) begin
      @(negedge clk_sys);
      cycles++;
    end
    if (timer_irq !== 1'b1) begin
      errors++;
      $display("Timer interrupt did not rise after the compare register was cleared");
    end

    // Back-to-back mix of RAM, GPIO and unmapped requests
    for (int i = 0; i < 24; i++) begin
      r = next_rand();
      case (r[1:0])
        2'd0: bus_access(1'b0, ram_addrs[r[4:2]], 32'h0, 4'hf);
        2'd1: bus_access(1'b1, ram_addrs[r[4:2]], next_rand(), r[11:8]);
        2'd2: bus_access(r[5], GpioStart | {29'h0, r[6], 2'b00}, next_rand(), r[11:8]);
        default: bus_access(r[5], 32'hc000_0000 | (r & 32'h0fff_fffc), next_rand(), 4'hf);
      endcase
    end
    bus_idle(1);
    wait_responses();
    bus_idle(2);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== verification/tb_clk_gen.sv ====
////////////////////////////////////////////////////////////
// Testbench clock and reset
////////////////////////////////////////////////////////////
module tb_clk_gen (
  output logic clk_sys_o,
  output logic rst_sys_no
);
  timeunit 1ns;
  timeprecision 1ps;

  // 10 ns period
  initial begin
    clk_sys_o = 1'b0;
    forever #5 clk_sys_o = ~clk_sys_o;
  end

  // Five cycles of reset, released on a falling edge
  initial begin
    rst_sys_no = 1'b0;
    repeat (5) @(posedge clk_sys_o);
    @(negedge clk_sys_o);
    rst_sys_no = 1'b1;
  end

endmodule

// ==== rtl/demo_system.sv ====
////////////////////////////////////////////////////////////
// Demo peripheral system
////////////////////////////////////////////////////////////
module demo_system (
  input  logic                              clk_sys_i,
  input  logic                              rst_sys_ni,

  input  logic                              host_req_i,
  input  logic                              host_we_i,
  input  logic [demo_pkg::BusBeWidth-1:0]   host_be_i,
  input  logic [demo_pkg::BusAddrWidth-1:0] host_addr_i,
  input  logic [demo_pkg::BusDataWidth-1:0] host_wdata_i,
  output logic                              host_rvalid_o,
  output logic [demo_pkg::BusDataWidth-1:0] host_rdata_o,
  output logic                              host_err_o,

  input  logic [demo_pkg::GpiWidth-1:0]     gp_i,
  output logic [demo_pkg::GpoWidth-1:0]     gp_o,
  output logic                              timer_irq_o
);
  import demo_pkg::*;

  logic                    ram_req, gpio_req, timer_req;
  logic                    ram_we, gpio_we, timer_we;
  logic                    ram_rvalid, gpio_rvalid, timer_rvalid;
  logic [BusBeWidth-1:0]   ram_be, gpio_be, timer_be;
  logic [BusAddrWidth-1:0] ram_addr, gpio_addr, timer_addr;
  logic [BusDataWidth-1:0] ram_wdata, gpio_wdata, timer_wdata;
  logic [BusDataWidth-1:0] ram_rdata, gpio_rdata, timer_rdata;

  demo_bus demo_bus_inst (
    .clk_sys_i     (clk_sys_i),
    .rst_sys_ni    (rst_sys_ni),
    .host_req_i    (host_req_i),
    .host_we_i     (host_we_i),
    .host_be_i     (host_be_i),
    .host_addr_i   (host_addr_i),
    .host_wdata_i  (host_wdata_i),
    .host_rvalid_o (host_rvalid_o),
    .host_rdata_o  (host_rdata_o),
    .host_err_o    (host_err_o),
    .ram_req_o     (ram_req),
    .ram_we_o      (ram_we),
    .ram_be_o      (ram_be),
    .ram_addr_o    (ram_addr),
    .ram_wdata_o   (ram_wdata),
    .ram_rvalid_i  (ram_rvalid),
    .ram_rdata_i   (ram_rdata),
    .gpio_req_o    (gpio_req),
    .gpio_we_o     (gpio_we),
    .gpio_be_o     (gpio_be),
    .gpio_addr_o   (gpio_addr),
    .gpio_wdata_o  (gpio_wdata),
    .gpio_rvalid_i (gpio_rvalid),
    .gpio_rdata_i  (gpio_rdata),
    .timer_req_o   (timer_req),
    .timer_we_o    (timer_we),
    .timer_be_o    (timer_be),
    .timer_addr_o  (timer_addr),
    .timer_wdata_o (timer_wdata),
    .timer_rvalid_i(timer_rvalid),
    .timer_rdata_i (timer_rdata)
  );

  demo_ram demo_ram_inst (
    .clk_sys_i (clk_sys_i),
    .rst_sys_ni(rst_sys_ni),
    .req_i     (ram_req),
    .we_i      (ram_we),
    .be_i      (ram_be),
    .addr_i    (ram_addr),
    .wdata_i   (ram_wdata),
    .rvalid_o  (ram_rvalid),
    .rdata_o   (ram_rdata)
  );

  demo_gpio demo_gpio_inst (
    .clk_sys_i (clk_sys_i),
    .rst_sys_ni(rst_sys_ni),
    .req_i     (gpio_req),
    .we_i      (gpio_we),
    .be_i      (gpio_be),
    .addr_i    (gpio_addr),
    .wdata_i   (gpio_wdata),
    .rvalid_o  (gpio_rvalid),
    .rdata_o   (gpio_rdata),
    .gp_i      (gp_i),
    .gp_o      (gp_o)
  );

  demo_timer demo_timer_inst (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .req_i      (timer_req),
    .we_i       (timer_we),
    .be_i       (timer_be),
    .addr_i     (timer_addr),
    .wdata_i    (timer_wdata),
    .rvalid_o   (timer_rvalid),
    .rdata_o    (timer_rdata),
    .timer_irq_o(timer_irq_o)
  );

endmodule

// ==== rtl/demo_timer.sv ====
////////////////////////////////////////////////////////////
// Machine timer
////////////////////////////////////////////////////////////
module demo_timer (
  input  logic                              clk_sys_i,
  input  logic                              rst_sys_ni,
  input  logic                              req_i,
  input  logic                              we_i,
  input  logic [demo_pkg::BusBeWidth-1:0]   be_i,
  input  logic [demo_pkg::BusAddrWidth-1:0] addr_i,
  input  logic [demo_pkg::BusDataWidth-1:0] wdata_i,
  output logic                              rvalid_o,
  output logic [demo_pkg::BusDataWidth-1:0] rdata_o,
  output logic                              timer_irq_o
);
  import demo_pkg::*;

  logic [RegOffsetWidth-1:0] offset;
  logic                      wr;
  logic [TimeWidth-1:0]      time_q;
  logic [TimeWidth-1:0]      time_d;
  logic [TimeWidth-1:0]      cmp_q;
  logic [TimeWidth-1:0]      cmp_d;

  assign offset = addr_i[RegOffsetWidth-1:0];
  assign wr     = req_i & we_i;

  always_comb begin
    time_d = time_q + 1'b1;
    cmp_d  = cmp_q;
    if (wr) begin
      case (offset)
        TimeLo: time_d[BusDataWidth-1:0] = apply_be(time_q[BusDataWidth-1:0], wdata_i, be_i);
        TimeHi: time_d[TimeWidth-1:BusDataWidth] =
                    apply_be(time_q[TimeWidth-1:BusDataWidth], wdata_i, be_i);
        CmpLo:  cmp_d[BusDataWidth-1:0] = apply_be(cmp_q[BusDataWidth-1:0], wdata_i, be_i);
        CmpHi:  cmp_d[TimeWidth-1:BusDataWidth] =
                    apply_be(cmp_q[TimeWidth-1:BusDataWidth], wdata_i, be_i);
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      time_q      <= '0;
      cmp_q       <= '0;
      rvalid_o    <= 1'b0;
      timer_irq_o <= 1'b0;
    end else begin
      time_q      <= time_d;
      cmp_q       <= cmp_d;
      rvalid_o    <= req_i;
      timer_irq_o <= (time_q >= cmp_q);
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      case (offset)
        TimeLo:  rdata_o <= time_q[BusDataWidth-1:0];
        TimeHi:  rdata_o <= time_q[TimeWidth-1:BusDataWidth];
        CmpLo:   rdata_o <= cmp_q[BusDataWidth-1:0];
        CmpHi:   rdata_o <= cmp_q[TimeWidth-1:BusDataWidth];
        default: rdata_o <= '0;
      endcase
    end
  end

  // Interrupt comes up no earlier than one full cycle out of reset
  irq_low_after_reset: assert property (
    @(posedge clk_sys_i) $rose(rst_sys_ni) |-> !timer_irq_o
  );

endmodule

// ==== rtl/demo_gpio.sv ====
////////////////////////////////////////////////////////////
// GPIO registers
////////////////////////////////////////////////////////////
module demo_gpio (
  input  logic                              clk_sys_i,
  input  logic                              rst_sys_ni,
  input  logic                              req_i,
  input  logic                              we_i,
  input  logic [demo_pkg::BusBeWidth-1:0]   be_i,
  input  logic [demo_pkg::BusAddrWidth-1:0] addr_i,
  input  logic [demo_pkg::BusDataWidth-1:0] wdata_i,
  output logic                              rvalid_o,
  output logic [demo_pkg::BusDataWidth-1:0] rdata_o,
  input  logic [demo_pkg::GpiWidth-1:0]     gp_i,
  output logic [demo_pkg::GpoWidth-1:0]     gp_o
);
  import demo_pkg::*;

  logic [RegOffsetWidth-1:0] offset;
  logic [GpiWidth-1:0]       gpi_meta_q;
  logic [GpiWidth-1:0]       gpi_sync_q;
  logic [BusDataWidth-1:0]   gpo_wide;
  logic [BusDataWidth-1:0]   gpo_merged;

  assign offset     = addr_i[RegOffsetWidth-1:0];
  assign gpo_wide   = {{(BusDataWidth-GpoWidth){1'b0}}, gp_o};
  assign gpo_merged = apply_be(gpo_wide, wdata_i, be_i);

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gp_o       <= '0;
      gpi_meta_q <= '0;
      gpi_sync_q <= '0;
      rvalid_o   <= 1'b0;
    end else begin
      gpi_meta_q <= gp_i;
      gpi_sync_q <= gpi_meta_q;
      rvalid_o   <= req_i;
      if (req_i && we_i && offset == GpioOut) begin
        gp_o <= gpo_merged[GpoWidth-1:0];
      end
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      case (offset)
        GpioOut: rdata_o <= gpo_wide;
        GpioIn:  rdata_o <= {{(BusDataWidth-GpiWidth){1'b0}}, gpi_sync_q};
        default: rdata_o <= '0;
      endcase
    end
  end

endmodule

// ==== rtl/demo_ram.sv ====
////////////////////////////////////////////////////////////
// Byte-enabled word RAM
////////////////////////////////////////////////////////////
module demo_ram (
  input  logic                              clk_sys_i,
  input  logic                              rst_sys_ni,
  input  logic                              req_i,
  input  logic                              we_i,
  input  logic [demo_pkg::BusBeWidth-1:0]   be_i,
  input  logic [demo_pkg::BusAddrWidth-1:0] addr_i,
  input  logic [demo_pkg::BusDataWidth-1:0] wdata_i,
  output logic                              rvalid_o,
  output logic [demo_pkg::BusDataWidth-1:0] rdata_o
);
  import demo_pkg::*;

  localparam int IdxWidth = $clog2(RamDepth);

  logic [BusDataWidth-1:0] mem [RamDepth];
  logic [IdxWidth-1:0]     word_idx;

  // Word index from address bits 15:2
  assign word_idx = addr_i[IdxWidth+1:2];

  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      if (we_i) begin
        mem[word_idx] <= apply_be(mem[word_idx], wdata_i, be_i);
      end
      rdata_o <= mem[word_idx];
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i;
    end
  end

endmodule

// ==== rtl/demo_bus.sv ====
////////////////////////////////////////////////////////////
// Peripheral bus decoder
////////////////////////////////////////////////////////////
module demo_bus (
  input  logic                              clk_sys_i,
  input  logic                              rst_sys_ni,

  input  logic                              host_req_i,
  input  logic                              host_we_i,
  input  logic [demo_pkg::BusBeWidth-1:0]   host_be_i,
  input  logic [demo_pkg::BusAddrWidth-1:0] host_addr_i,
  input  logic [demo_pkg::BusDataWidth-1:0] host_wdata_i,
  output logic                              host_rvalid_o,
  output logic [demo_pkg::BusDataWidth-1:0] host_rdata_o,
  output logic                              host_err_o,

  output logic                              ram_req_o,
  output logic                              ram_we_o,
  output logic [demo_pkg::BusBeWidth-1:0]   ram_be_o,
  output logic [demo_pkg::BusAddrWidth-1:0] ram_addr_o,
  output logic [demo_pkg::BusDataWidth-1:0] ram_wdata_o,
  input  logic                              ram_rvalid_i,
  input  logic [demo_pkg::BusDataWidth-1:0] ram_rdata_i,

  output logic                              gpio_req_o,
  output logic                              gpio_we_o,
  output logic [demo_pkg::BusBeWidth-1:0]   gpio_be_o,
  output logic [demo_pkg::BusAddrWidth-1:0] gpio_addr_o,
  output logic [demo_pkg::BusDataWidth-1:0] gpio_wdata_o,
  input  logic                              gpio_rvalid_i,
  input  logic [demo_pkg::BusDataWidth-1:0] gpio_rdata_i,

  output logic                              timer_req_o,
  output logic                              timer_we_o,
  output logic [demo_pkg::BusBeWidth-1:0]   timer_be_o,
  output logic [demo_pkg::BusAddrWidth-1:0] timer_addr_o,
  output logic [demo_pkg::BusDataWidth-1:0] timer_wdata_o,
  input  logic                              timer_rvalid_i,
  input  logic [demo_pkg::BusDataWidth-1:0] timer_rdata_i
);
  import demo_pkg::*;

  bus_device_e dev_sel;
  bus_device_e dev_q;
  logic        err_q;

  always_comb begin
    dev_sel = DevNone;
    if ((host_addr_i & ~(RamSize - 1)) == RamStart) begin
      dev_sel = DevRam;
    end else if ((host_addr_i & ~(GpioSize - 1)) == GpioStart) begin
      dev_sel = DevGpio;
    end else if ((host_addr_i & ~(TimerSize - 1)) == TimerStart) begin
      dev_sel = DevTimer;
    end
  end

  // Only the selected device sees the request pulse
  assign ram_req_o   = host_req_i & (dev_sel == DevRam);
  assign gpio_req_o  = host_req_i & (dev_sel == DevGpio);
  assign timer_req_o = host_req_i & (dev_sel == DevTimer);

  assign ram_we_o      = host_we_i;
  assign ram_be_o      = host_be_i;
  assign ram_addr_o    = host_addr_i;
  assign ram_wdata_o   = host_wdata_i;
  assign gpio_we_o     = host_we_i;
  assign gpio_be_o     = host_be_i;
  assign gpio_addr_o   = host_addr_i;
  assign gpio_wdata_o  = host_wdata_i;
  assign timer_we_o    = host_we_i;
  assign timer_be_o    = host_be_i;
  assign timer_addr_o  = host_addr_i;
  assign timer_wdata_o = host_wdata_i;

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      dev_q <= DevNone;
      err_q <= 1'b0;
    end else begin
      dev_q <= dev_sel;
      err_q <= host_req_i & (dev_sel == DevNone);
    end
  end

  always_comb begin
    case (dev_q)
      DevRam: begin
        host_rvalid_o = ram_rvalid_i;
        host_rdata_o  = ram_rdata_i;
      end
      DevGpio: begin
        host_rvalid_o = gpio_rvalid_i;
        host_rdata_o  = gpio_rdata_i;
      end
      DevTimer: begin
        host_rvalid_o = timer_rvalid_i;
        host_rdata_o  = timer_rdata_i;
      end
      default: begin
        host_rvalid_o = err_q;
        host_rdata_o  = '0;
      end
    endcase
  end

  assign host_err_o = err_q;

  // Devices must answer one cycle after the request and never on their own
  rvalid_follows_req: assert property (
    @(posedge clk_sys_i) disable iff (!rst_sys_ni)
    host_rvalid_o |-> $past(host_req_i)
  );

endmodule

// ==== rtl/demo_pkg.sv ====
////////////////////////////////////////////////////////////
// Demo system address map and types
////////////////////////////////////////////////////////////
package demo_pkg;

  localparam int BusAddrWidth   = 32;
  localparam int BusDataWidth   = 32;
  localparam int BusBeWidth     = BusDataWidth / 8;
  localparam int RegOffsetWidth = 12;
  localparam int TimeWidth      = 2 * BusDataWidth;

  // Device windows
  localparam logic [BusAddrWidth-1:0] RamStart   = 32'h0010_0000;
  localparam logic [BusAddrWidth-1:0] RamSize    = 32'h0001_0000;
  localparam logic [BusAddrWidth-1:0] GpioStart  = 32'h8000_0000;
  localparam logic [BusAddrWidth-1:0] GpioSize   = 32'h0000_1000;
  localparam logic [BusAddrWidth-1:0] TimerStart = 32'h8000_2000;
  localparam logic [BusAddrWidth-1:0] TimerSize  = 32'h0000_1000;

  localparam int RamDepth = RamSize / 4;

  localparam int GpiWidth = 8;
  localparam int GpoWidth = 16;

  typedef enum logic [1:0] {
    DevRam,
    DevGpio,
    DevTimer,
    DevNone
  } bus_device_e;

  typedef enum logic [RegOffsetWidth-1:0] {
    GpioOut = 12'h000,
    GpioIn  = 12'h004
  } gpio_reg_e;

  typedef enum logic [RegOffsetWidth-1:0] {
    TimeLo = 12'h000,
    TimeHi = 12'h004,
    CmpLo  = 12'h008,
    CmpHi  = 12'h00C
  } timer_reg_e;

  // Byte-lane merge of write data into an old word
  function automatic logic [BusDataWidth-1:0] apply_be(input logic [BusDataWidth-1:0] old_data,
                                                       input logic [BusDataWidth-1:0] new_data,
                                                       input logic [BusBeWidth-1:0]   be);
    logic [BusDataWidth-1:0] merged;
    merged = old_data;
    for (int b = 0; b < BusBeWidth; b++) begin
      if (be[b]) begin
        merged[b*8 +: 8] = new_data[b*8 +: 8];
      end
    end
    return merged;
  endfunction

endpackage
